// File: tb.f
+incdir+design
design/breakoutPkg.sv
design/paddleControl.sv
design/ballPhysics.sv
design/pixelRenderer.sv
design/breakoutTop.sv
tb/breakoutTb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module breakoutTb -f tb.f -o simBreakout \
    && ./obj_dir/simBreakout | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }

// File: tb/breakoutTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "breakout_consts.svh"

module breakoutTb;
    import breakoutPkg::*;

    // row kinds
    localparam int KIND_STATIC = 0;
    localparam int KIND_MODEL  = 1;
    localparam int KIND_BALL   = 2;
    localparam int KIND_PADDLE = 3;
    localparam int KIND_RANDOM = 4;
    localparam int KIND_MISS   = 5;

    logic  clock;
    logic  reset;
    logic  step;
    logic  moveLeft;
    logic  moveRight;
    coordT pixelX;
    coordT pixelY;
    rgbT   pixelColor;
    scoreT score;

    // stimulus table with one entry per row
    string rowName [$];
    int    rowSteps [$];
    logic  rowLeft [$];
    logic  rowRight [$];
    int    rowKind [$];
    coordT rowX [$];
    coordT rowY [$];
    rgbT   rowColor [$];
    scoreT rowScore [$];

    // reference game state
    coordT       mBallX;
    coordT       mBallY;
    logic        mGoRight;
    logic        mGoDown;
    coordT       mPaddleX;
    brickMaskT   mBricks;
    int          mScore;
    int          missCount;
    logic [31:0] rngState;

    breakoutTop breakoutTop_i (
        .clock      (clock),
        .reset      (reset),
        .step       (step),
        .moveLeft   (moveLeft),
        .moveRight  (moveRight),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColor (pixelColor),
        .score      (score)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////
    // run control
    ////////////////////
    task automatic abortRun(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // counts falling edges by sampling the clock every half nanosecond
    task automatic waitFalling(input int count);
        int   seen;
        int   ticks;
        logic last;
        seen  = 0;
        ticks = 0;
        last  = clock;
        while (seen < count) begin
            #0.5;
            ticks++;
            if (last && !clock) begin
                seen++;
            end
            last = clock;
            if (ticks > count * 50) begin
                abortRun("timed out waiting for a falling clock edge");
            end
        end
    endtask

    task automatic addRow(input string name, input int steps, input logic left,
                          input logic right, input int kind, input coordT x,
                          input coordT y, input rgbT color, input scoreT sc);
        rowName.push_back(name);
        rowSteps.push_back(steps);
        rowLeft.push_back(left);
        rowRight.push_back(right);
        rowKind.push_back(kind);
        rowX.push_back(x);
        rowY.push_back(y);
        rowColor.push_back(color);
        rowScore.push_back(sc);
    endtask

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] seed);
        logic [31:0] v;
        v = seed;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic scoreT toBcd(input int value);
        scoreT bcd;
        int    rest;
        rest = value;
        for (int d = 0; d < 4; d++) begin
            bcd[4*d +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return bcd;
    endfunction

    function automatic coordT brickLeftEdge(input int i);
        case (i)
            0: return `BRICK0_LEFT;
            1: return `BRICK1_LEFT;
            2: return `BRICK2_LEFT;
            3: return `BRICK3_LEFT;
            default: return `BRICK4_LEFT;
        endcase
    endfunction

    function automatic coordT brickRightEdge(input int i);
        case (i)
            0: return `BRICK0_RIGHT;
            1: return `BRICK1_RIGHT;
            2: return `BRICK2_RIGHT;
            3: return `BRICK3_RIGHT;
            default: return `BRICK4_RIGHT;
        endcase
    endfunction

    function automatic rgbT brickColorOf(input int i);
        case (i)
            0: return `COLOR_BRICK0;
            1: return `COLOR_BRICK1;
            2: return `COLOR_BRICK2;
            3: return `COLOR_BRICK3;
            default: return `COLOR_BRICK4;
        endcase
    endfunction

    // all bounds inclusive
    function automatic logic inRect(input coordT x, input coordT y, input coordT x0,
                                    input coordT x1, input coordT y0, input coordT y1);
        return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
    endfunction

    function automatic rgbT expectedColor(input coordT x, input coordT y);
        if (inRect(x, y, `BORDER_LEFT_X0, `BORDER_LEFT_X1, `BORDER_LEFT_Y0, `BORDER_LEFT_Y1)
            || inRect(x, y, `BORDER_TOP_X0, `BORDER_TOP_X1, `BORDER_TOP_Y0, `BORDER_TOP_Y1)
            || inRect(x, y, `BORDER_RIGHT_X0, `BORDER_RIGHT_X1,
                      `BORDER_RIGHT_Y0, `BORDER_RIGHT_Y1)
            || inRect(x, y, `BORDER_BOTTOM_X0, `BORDER_BOTTOM_X1,
                      `BORDER_BOTTOM_Y0, `BORDER_BOTTOM_Y1)) begin
            return `COLOR_BORDER;
        end
        for (int i = 0; i < `BRICK_COUNT; i++) begin
            if (mBricks[i] && inRect(x, y, brickLeftEdge(i), brickRightEdge(i),
                                     `BRICK_TOP, `BRICK_BOTTOM)) begin
                return brickColorOf(i);
            end
        end
        if (inRect(x, y, mBallX, mBallX + `BALL_SIZE - 10'd1,
                   mBallY, mBallY + `BALL_SIZE - 10'd1)) begin
            return `COLOR_BALL;
        end
        // paddle drawn up to and including x plus width
        if (inRect(x, y, mPaddleX, mPaddleX + `PADDLE_WIDTH, `PADDLE_TOP, `PADDLE_BOTTOM)) begin
            return `COLOR_PADDLE;
        end
        return `COLOR_BACKGROUND;
    endfunction

    task automatic modelReset();
        mBallX    = `BALL_START_X;
        mBallY    = `BALL_START_Y;
        mGoRight  = 1'b1;
        mGoDown   = 1'b0;
        mPaddleX  = `PADDLE_START_X;
        mBricks   = '1;
        mScore    = 0;
        missCount = 0;
    endtask

    // one game step where every rule reads the state from before the step
    task automatic modelStep(input logic left, input logic right);
        coordT ballRight;
        coordT ballBottom;
        coordT oldPaddle;
        int    hit;
        logic  newRight;
        logic  newDown;
        ballRight  = mBallX + `BALL_SIZE - 10'd1;
        ballBottom = mBallY + `BALL_SIZE - 10'd1;
        oldPaddle  = mPaddleX;
        if (left && (mPaddleX > 10'd0)) begin
            mPaddleX = mPaddleX - `MOVE_STEP;
        end else if (right && (mPaddleX + `PADDLE_WIDTH < `SCREEN_WIDTH - `MOVE_STEP)) begin
            mPaddleX = mPaddleX + `MOVE_STEP;
        end
        if (ballBottom >= `BALL_MISS_Y) begin
            // only the ball restarts on a miss
            mBallX   = `BALL_START_X;
            mBallY   = `BALL_START_Y;
            mGoRight = 1'b1;
            mGoDown  = 1'b0;
            missCount++;
        end else begin
            hit = -1;
            for (int i = 0; i < `BRICK_COUNT; i++) begin
                if (mBricks[i] && (mBallY < `BRICK_BOTTOM) && (mBallX > brickLeftEdge(i))
                    && (ballRight < brickRightEdge(i))) begin
                    hit = i;
                end
            end
            if (hit >= 0) begin
                mBricks[hit] = 1'b0;
                mScore = (mScore + 1) % 10000;
            end
            newRight = mGoRight;
            newDown  = mGoDown;
            if (mBallX <= `FIELD_LEFT) begin
                newRight = 1'b1;
            end else if (ballRight >= `FIELD_RIGHT) begin
                newRight = 1'b0;
            end else if (mBallY <= `FIELD_TOP) begin
                newDown = 1'b1;
            end else if ((ballBottom >= `PADDLE_TOP) && (mBallX >= oldPaddle)
                         && (ballRight <= oldPaddle + `PADDLE_WIDTH)) begin
                newDown = 1'b0;
            end else if (hit >= 0) begin
                newDown = 1'b1;
            end
            mGoRight = newRight;
            mGoDown  = newDown;
            mBallX   = newRight ? mBallX + 10'd1 : mBallX - 10'd1;
            mBallY   = newDown ? mBallY + 10'd1 : mBallY - 10'd1;
        end
    endtask

    ////////////////////
    // DUT access
    ////////////////////
    // entered and left on a falling edge
    task automatic applyStep(input logic left, input logic right);
        moveLeft  = left;
        moveRight = right;
        step      = 1'b1;
        waitFalling(1);
        step = 1'b0;
        modelStep(left, right);
        waitFalling(1);
    endtask

    task automatic checkPixel(input string name, input coordT x, input coordT y,
                              input rgbT expColor, input scoreT expScore);
        pixelX = x;
        pixelY = y;
        // colour follows the coordinate by one cycle and is read a cycle later
        waitFalling(2);
        assert (pixelColor === expColor)
            else abortRun($sformatf("Mismatch in %s: pixel (%0d,%0d) expected %h, actual %h",
                                    name, x, y, expColor, pixelColor));
        assert (score === expScore)
            else abortRun($sformatf("Mismatch in %s: score expected %h, actual %h",
                                    name, expScore, score));
    endtask

    // somewhere in and around the ball
    task automatic probeNearBall(input string name);
        coordT x;
        coordT y;
        rngState = xorshift(rngState);
        x = mBallX - 10'd4 + coordT'(rngState % 32'd18);
        rngState = xorshift(rngState);
        y = mBallY - 10'd4 + coordT'(rngState % 32'd18);
        checkPixel(name, x, y, expectedColor(x, y), toBcd(mScore));
    endtask

    ////////////////////
    // stimulus table
    ////////////////////
    task automatic buildTable();
        // state right after reset
        addRow("borderLeft", 0, 1'b0, 1'b0, KIND_STATIC, 10'd45, 10'd200, 12'h0F0, 16'h0000);
        addRow("borderTop", 0, 1'b0, 1'b0, KIND_STATIC, 10'd300, 10'd35, 12'h0F0, 16'h0000);
        addRow("borderRight", 0, 1'b0, 1'b0, KIND_STATIC, 10'd635, 10'd300, 12'h0F0, 16'h0000);
        addRow("borderBottom", 0, 1'b0, 1'b0, KIND_STATIC, 10'd300, 10'd475, 12'h0F0, 16'h0000);
        addRow("brick0", 0, 1'b0, 1'b0, KIND_STATIC, 10'd95, 10'd57, 12'hF00, 16'h0000);
        addRow("brick1", 0, 1'b0, 1'b0, KIND_STATIC, 10'd215, 10'd57, 12'h0F0, 16'h0000);
        addRow("brick2", 0, 1'b0, 1'b0, KIND_STATIC, 10'd335, 10'd57, 12'h00F, 16'h0000);
        addRow("brick3", 0, 1'b0, 1'b0, KIND_STATIC, 10'd455, 10'd57, 12'hFF0, 16'h0000);
        addRow("brick4", 0, 1'b0, 1'b0, KIND_STATIC, 10'd575, 10'd57, 12'h0FF, 16'h0000);
        addRow("ballStart", 0, 1'b0, 1'b0, KIND_STATIC, 10'd320, 10'd305, 12'hF00, 16'h0000);
        addRow("paddleStart", 0, 1'b0, 1'b0, KIND_STATIC, 10'd320, 10'd462, 12'hF04, 16'h0000);
        addRow("background", 0, 1'b0, 1'b0, KIND_STATIC, 10'd200, 10'd200, 12'h000, 16'h0000);
        // free flight up and right
        addRow("ballMoves", 20, 1'b0, 1'b0, KIND_BALL, 10'd0, 10'd0, 12'h000, 16'h0000);
        addRow("ballOldSpot", 0, 1'b0, 1'b0, KIND_STATIC, 10'd320, 10'd305, 12'h000, 16'h0000);
        // ball top at 61 under brick 4 so the next step hits it
        addRow("ballToBricks", 219, 1'b0, 1'b0, KIND_STATIC, 10'd575, 10'd57, 12'h0FF, 16'h0000);
        addRow("ballUnderBrick", 0, 1'b0, 1'b0, KIND_STATIC, 10'd558, 10'd66, 12'hF00, 16'h0000);
        addRow("brick4Hit", 1, 1'b0, 1'b0, KIND_STATIC, 10'd600, 10'd55, 12'h000, 16'h0001);
        addRow("brick4Gone", 0, 1'b0, 1'b0, KIND_STATIC, 10'd575, 10'd57, 12'h000, 16'h0001);
        addRow("ballDown", 30, 1'b0, 1'b0, KIND_BALL, 10'd0, 10'd0, 12'h000, 16'h0000);
        addRow("rightWall", 60, 1'b0, 1'b0, KIND_BALL, 10'd0, 10'd0, 12'h000, 16'h0000);
        // paddle moves
        addRow("paddleLeft", 30, 1'b1, 1'b0, KIND_PADDLE, 10'd0, 10'd0, 12'h000, 16'h0000);
        addRow("paddleTrail", 0, 1'b0, 1'b0, KIND_MODEL, 10'd323, 10'd462, 12'h000, 16'h0000);
        addRow("paddleRight", 50, 1'b0, 1'b1, KIND_PADDLE, 10'd0, 10'd0, 12'h000, 16'h0000);
        addRow("paddleBoth", 10, 1'b1, 1'b1, KIND_PADDLE, 10'd0, 10'd0, 12'h000, 16'h0000);
        addRow("paddleClamp", 320, 1'b1, 1'b0, KIND_MODEL, 10'd0, 10'd462, 12'h000, 16'h0000);
        addRow("paddleClampEdge", 0, 1'b1, 1'b0, KIND_STATIC, 10'd64, 10'd462, 12'hF04, 16'h0001);
        // ball falls past the paddle parked at the left
        addRow("missReturn", 2000, 1'b1, 1'b0, KIND_MISS, 10'd320, 10'd305, 12'h000, 16'h0000);
        addRow("missScore", 0, 1'b1, 1'b0, KIND_STATIC, 10'd320, 10'd305, 12'hF00, 16'h0001);
        addRow("randomProbes", 400, 1'b0, 1'b1, KIND_RANDOM, 10'd0, 10'd0, 12'h000, 16'h0000);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        int missBefore;
        int used;
        reset      = 1'b1;
        step       = 1'b0;
        moveLeft   = 1'b0;
        moveRight  = 1'b0;
        pixelX     = '0;
        pixelY     = '0;
        rngState   = 32'hfb72_8f34;
        modelReset();
        buildTable();
        waitFalling(5);
        reset = 1'b0;

        for (int r = 0; r < rowName.size(); r++) begin
            if (rowKind[r] == KIND_MISS) begin
                // steps is the budget here
                missBefore = missCount;
                used = 0;
                while (missCount == missBefore) begin
                    applyStep(rowLeft[r], rowRight[r]);
                    used++;
                    assert (used <= rowSteps[r])
                        else abortRun($sformatf("%s: no miss within %0d steps",
                                                rowName[r], rowSteps[r]));
                end
            end else begin
                for (int s = 0; s < rowSteps[r]; s++) begin
                    applyStep(rowLeft[r], rowRight[r]);
                    if (rowKind[r] == KIND_RANDOM) begin
                        probeNearBall(rowName[r]);
                    end
                end
            end
            case (rowKind[r])
                KIND_STATIC: begin
                    checkPixel(rowName[r], rowX[r], rowY[r], rowColor[r], rowScore[r]);
                end
                KIND_MODEL, KIND_MISS: begin
                    checkPixel(rowName[r], rowX[r], rowY[r],
                               expectedColor(rowX[r], rowY[r]), toBcd(mScore));
                end
                KIND_BALL: begin
                    checkPixel(rowName[r], mBallX + 10'd5, mBallY + 10'd5,
                               expectedColor(mBallX + 10'd5, mBallY + 10'd5), toBcd(mScore));
                end
                KIND_PADDLE: begin
                    checkPixel(rowName[r], mPaddleX, `PADDLE_TOP + 10'd2,
                               expectedColor(mPaddleX, `PADDLE_TOP + 10'd2), toBcd(mScore));
                end
                default: begin
                end
            endcase
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/breakoutTop.sv
`timescale 1ns/1ps
`default_nettype none

module breakoutTop (
    input  logic                clock,
    input  logic                reset,
    input  logic                step,
    input  logic                moveLeft,
    input  logic                moveRight,
    input  breakoutPkg::coordT  pixelX,
    input  breakoutPkg::coordT  pixelY,
    output breakoutPkg::rgbT    pixelColor,
    output breakoutPkg::scoreT  score
);
    import breakoutPkg::*;

    // paddle left edge
    coordT     paddleX;
    // ball top-left corner
    coordT     ballX;
    coordT     ballY;
    brickMaskT brickAlive;

    ////////////////////
    // game state
    ////////////////////
    paddleControl paddleControl_i (
        .clock     (clock),
        .reset     (reset),
        .step      (step),
        .moveLeft  (moveLeft),
        .moveRight (moveRight),
        .paddleX   (paddleX)
    );

    // needs the paddle for the bounce test
    ballPhysics ballPhysics_i (
        .clock      (clock),
        .reset      (reset),
        .step       (step),
        .paddleX    (paddleX),
        .ballX      (ballX),
        .ballY      (ballY),
        .brickAlive (brickAlive),
        .score      (score)
    );

    ////////////////////
    // video out
    ////////////////////
    // one cycle from coordinate to colour
    pixelRenderer pixelRenderer_i (
        .clock      (clock),
        .reset      (reset),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .ballX      (ballX),
        .ballY      (ballY),
        .paddleX    (paddleX),
        .brickAlive (brickAlive),
        .pixelColor (pixelColor)
    );

endmodule

`default_nettype wire

// File: design/pixelRenderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "breakout_consts.svh"

module pixelRenderer (
    input  logic                   clock,
    input  logic                   reset,
    input  breakoutPkg::coordT     pixelX,
    input  breakoutPkg::coordT     pixelY,
    input  breakoutPkg::coordT     ballX,
    input  breakoutPkg::coordT     ballY,
    input  breakoutPkg::coordT     paddleX,
    input  breakoutPkg::brickMaskT brickAlive,
    output breakoutPkg::rgbT       pixelColor
);
    import breakoutPkg::*;

    localparam coordT brickLeft [`BRICK_COUNT] = '{
        `BRICK0_LEFT, `BRICK1_LEFT, `BRICK2_LEFT, `BRICK3_LEFT, `BRICK4_LEFT
    };
    localparam coordT brickRight [`BRICK_COUNT] = '{
        `BRICK0_RIGHT, `BRICK1_RIGHT, `BRICK2_RIGHT, `BRICK3_RIGHT, `BRICK4_RIGHT
    };
    localparam rgbT brickColor [`BRICK_COUNT] = '{
        `COLOR_BRICK0, `COLOR_BRICK1, `COLOR_BRICK2, `COLOR_BRICK3, `COLOR_BRICK4
    };

    logic      onBorder;
    logic      onBall;
    logic      onPaddle;
    brickMaskT onBrick;
    rgbT       brickPick;
    rgbT       colorNext;

    // inclusive range test
    function automatic logic inSpan(input coordT value, input coordT low, input coordT high);
        return (value >= low) && (value <= high);
    endfunction

    ////////////////////
    // region decode
    ////////////////////
    assign onBorder =
        (inSpan(pixelX, `BORDER_LEFT_X0, `BORDER_LEFT_X1)
            && inSpan(pixelY, `BORDER_LEFT_Y0, `BORDER_LEFT_Y1))
        || (inSpan(pixelX, `BORDER_TOP_X0, `BORDER_TOP_X1)
            && inSpan(pixelY, `BORDER_TOP_Y0, `BORDER_TOP_Y1))
        || (inSpan(pixelX, `BORDER_RIGHT_X0, `BORDER_RIGHT_X1)
            && inSpan(pixelY, `BORDER_RIGHT_Y0, `BORDER_RIGHT_Y1))
        || (inSpan(pixelX, `BORDER_BOTTOM_X0, `BORDER_BOTTOM_X1)
            && inSpan(pixelY, `BORDER_BOTTOM_Y0, `BORDER_BOTTOM_Y1));

    assign onBall = inSpan(pixelX, ballX, ballX + `BALL_SIZE - 10'd1)
                    && inSpan(pixelY, ballY, ballY + `BALL_SIZE - 10'd1);

    // paddle right edge drawn inclusive
    assign onPaddle = inSpan(pixelX, paddleX, paddleX + `PADDLE_WIDTH)
                      && inSpan(pixelY, `PADDLE_TOP, `PADDLE_BOTTOM);

    // dead bricks drop out here
    always_comb begin
        brickPick = `COLOR_BACKGROUND;
        for (int i = 0; i < `BRICK_COUNT; i++) begin
            onBrick[i] = brickAlive[i] && inSpan(pixelX, brickLeft[i], brickRight[i])
                         && inSpan(pixelY, `BRICK_TOP, `BRICK_BOTTOM);
        end
        for (int i = `BRICK_COUNT - 1; i >= 0; i--) begin
            if (onBrick[i]) begin
                brickPick = brickColor[i];
            end
        end
    end

    ////////////////////
    // priority and output register
    ////////////////////
    always_comb begin
        if (onBorder) begin
            colorNext = `COLOR_BORDER;
        end else if (|onBrick) begin
            colorNext = brickPick;
        end else if (onBall) begin
            colorNext = `COLOR_BALL;
        end else if (onPaddle) begin
            colorNext = `COLOR_PADDLE;
        end else begin
            colorNext = `COLOR_BACKGROUND;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pixelColor <= `COLOR_BACKGROUND;
        end else begin
            pixelColor <= colorNext;
        end
    end

    // game state and scan inputs must all be resolved
    colorKnown: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(pixelColor))
        else $error("pixel colour unknown");

endmodule

`default_nettype wire

// File: design/ballPhysics.sv
`timescale 1ns/1ps
`default_nettype none

`include "breakout_consts.svh"

module ballPhysics (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   step,
    input  breakoutPkg::coordT     paddleX,
    output breakoutPkg::coordT     ballX,
    output breakoutPkg::coordT     ballY,
    output breakoutPkg::brickMaskT brickAlive,
    output breakoutPkg::scoreT     score
);
    import breakoutPkg::*;

    // brick spans, left and right exclusive for hits
    localparam coordT brickLeft [`BRICK_COUNT] = '{
        `BRICK0_LEFT, `BRICK1_LEFT, `BRICK2_LEFT, `BRICK3_LEFT, `BRICK4_LEFT
    };
    localparam coordT brickRight [`BRICK_COUNT] = '{
        `BRICK0_RIGHT, `BRICK1_RIGHT, `BRICK2_RIGHT, `BRICK3_RIGHT, `BRICK4_RIGHT
    };

    // 1 means right / down
    logic      dirRight;
    logic      dirDown;
    logic      dirRightNext;
    logic      dirDownNext;
    coordT     ballRight;
    coordT     ballBottom;
    coordT     paddleRight;
    coordT     ballXNext;
    coordT     ballYNext;
    brickMaskT brickHit;
    logic      anyHit;
    logic      miss;
    logic      onPaddle;
    scoreT     scoreNext;

    assign ballRight   = ballX + `BALL_SIZE - 10'd1;
    assign ballBottom  = ballY + `BALL_SIZE - 10'd1;
    assign paddleRight = paddleX + `PADDLE_WIDTH;

    assign miss     = ballBottom >= `BALL_MISS_Y;
    // ball x span fully over the paddle
    assign onPaddle = (ballBottom >= `PADDLE_TOP) && (ballX >= paddleX)
                      && (ballRight <= paddleRight);

    ////////////////////
    // brick hits
    ////////////////////
    always_comb begin
        for (int i = 0; i < `BRICK_COUNT; i++) begin
            brickHit[i] = brickAlive[i] && (ballY < `BRICK_BOTTOM)
                          && (ballX > brickLeft[i]) && (ballRight < brickRight[i]);
        end
    end

    // spans are disjoint, at most one bit set
    assign anyHit = |brickHit;

    // BCD add of one hit, ripple through digits
    always_comb begin
        logic       carry;
        logic [3:0] digit;
        carry     = anyHit;
        scoreNext = score;
        for (int d = 0; d < 4; d++) begin
            digit = score[4*d +: 4];
            if (carry) begin
                if (digit == 4'd9) begin
                    scoreNext[4*d +: 4] = 4'd0;
                end else begin
                    scoreNext[4*d +: 4] = digit + 4'd1;
                    carry = 1'b0;
                end
            end
        end
    end

    ////////////////////
    // bounce rules
    ////////////////////
    // first match wins, walls before paddle before bricks
    always_comb begin
        dirRightNext = dirRight;
        dirDownNext  = dirDown;
        if (ballX <= `FIELD_LEFT) begin
            dirRightNext = 1'b1;
        end else if (ballRight >= `FIELD_RIGHT) begin
            dirRightNext = 1'b0;
        end else if (ballY <= `FIELD_TOP) begin
            dirDownNext = 1'b1;
        end else if (onPaddle) begin
            dirDownNext = 1'b0;
        end else if (anyHit) begin
            dirDownNext = 1'b1;
        end
    end

    // one pixel per axis per step
    assign ballXNext = dirRightNext ? ballX + 10'd1 : ballX - 10'd1;
    assign ballYNext = dirDownNext  ? ballY + 10'd1 : ballY - 10'd1;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ballX      <= `BALL_START_X;
            ballY      <= `BALL_START_Y;
            dirRight   <= 1'b1;
            dirDown    <= 1'b0;
            brickAlive <= '1;
            score      <= '0;
        end else if (step) begin
            if (miss) begin
                // back to start, bricks and score untouched
                ballX    <= `BALL_START_X;
                ballY    <= `BALL_START_Y;
                dirRight <= 1'b1;
                dirDown  <= 1'b0;
            end else begin
                ballX      <= ballXNext;
                ballY      <= ballYNext;
                dirRight   <= dirRightNext;
                dirDown    <= dirDownNext;
                brickAlive <= brickAlive & ~brickHit;
                score      <= scoreNext;
            end
        end
    end

    scoreIsBcd: assert property (@(posedge clock) disable iff (reset)
        (score[3:0] <= 4'd9) && (score[7:4] <= 4'd9)
        && (score[11:8] <= 4'd9) && (score[15:12] <= 4'd9))
        else $error("score digit out of BCD range");

    // walls must keep the ball on screen
    ballOnScreen: assert property (@(posedge clock) disable iff (reset)
        ballX + `BALL_SIZE <= `SCREEN_WIDTH)
        else $error("ball left the screen");

endmodule

`default_nettype wire

// File: design/paddleControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "breakout_consts.svh"

module paddleControl (
    input  logic               clock,
    input  logic               reset,
    input  logic               step,
    input  logic               moveLeft,
    input  logic               moveRight,
    output breakoutPkg::coordT paddleX
);
    import breakoutPkg::*;

    coordT paddleRight;
    coordT paddleNext;

    assign paddleRight = paddleX + `PADDLE_WIDTH;

    // left wins over right
    // stop at either screen edge
    always_comb begin
        paddleNext = paddleX;
        if (moveLeft && (paddleX > 10'd0)) begin
            paddleNext = paddleX - `MOVE_STEP;
        end else if (moveRight && (paddleRight < `SCREEN_WIDTH - `MOVE_STEP)) begin
            paddleNext = paddleX + `MOVE_STEP;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            paddleX <= `PADDLE_START_X;
        end else if (step) begin
            paddleX <= paddleNext;
        end
    end

    paddleOnScreen: assert property (@(posedge clock) disable iff (reset)
        paddleRight <= `SCREEN_WIDTH)
        else $error("paddle past right edge");

endmodule

`default_nettype wire

// File: design/breakoutPkg.sv
`default_nettype none

package breakoutPkg;

    // screen coordinate, x or y
    typedef logic [9:0] coordT;

    // pixel colour
    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgbT;

    // one bit per brick, set while alive
    typedef logic [4:0] brickMaskT;

    // four BCD digits
    // least significant digit in the low nibble
    typedef logic [15:0] scoreT;

endpackage

`default_nettype wire

// File: design/breakout_consts.svh
`ifndef BREAKOUT_CONSTS_SVH
`define BREAKOUT_CONSTS_SVH

////////////////////
// playfield walls
////////////////////
// left edge at or below this turns the ball right
`define FIELD_LEFT        10'd52
`define FIELD_RIGHT       10'd630
`define FIELD_TOP         10'd42
// bottom edge at or past this is a miss
`define BALL_MISS_Y       10'd470

// border rectangles, all bounds inclusive
`define BORDER_LEFT_X0    10'd42
`define BORDER_LEFT_X1    10'd51
`define BORDER_LEFT_Y0    10'd42
`define BORDER_LEFT_Y1    10'd471
`define BORDER_TOP_X0     10'd42
`define BORDER_TOP_X1     10'd631
`define BORDER_TOP_Y0     10'd32
`define BORDER_TOP_Y1     10'd42
`define BORDER_RIGHT_X0   10'd631
`define BORDER_RIGHT_X1   10'd640
`define BORDER_RIGHT_Y0   10'd32
`define BORDER_RIGHT_Y1   10'd480
`define BORDER_BOTTOM_X0  10'd42
`define BORDER_BOTTOM_X1  10'd631
`define BORDER_BOTTOM_Y0  10'd471
`define BORDER_BOTTOM_Y1  10'd480

`define SCREEN_WIDTH      10'd640

////////////////////
// ball and paddle
////////////////////
`define BALL_SIZE         10'd10
// ball starts moving right and up
`define BALL_START_X      10'd315
`define BALL_START_Y      10'd300
`define PADDLE_TOP        10'd460
`define PADDLE_BOTTOM     10'd465
`define PADDLE_WIDTH      10'd64
`define PADDLE_START_X    10'd288
`define MOVE_STEP         10'd1

////////////////////
// brick row
////////////////////
`define BRICK_TOP         10'd52
`define BRICK_BOTTOM      10'd62
`define BRICK_COUNT       5
`define BRICK0_LEFT       10'd60
`define BRICK1_LEFT       10'd180
`define BRICK2_LEFT       10'd300
`define BRICK3_LEFT       10'd420
`define BRICK4_LEFT       10'd540
`define BRICK0_RIGHT      10'd130
`define BRICK1_RIGHT      10'd250
`define BRICK2_RIGHT      10'd370
`define BRICK3_RIGHT      10'd490
`define BRICK4_RIGHT      10'd610

// colours as 4-bit red, green, blue
`define COLOR_BORDER      12'h0F0
`define COLOR_BALL        12'hF00
`define COLOR_PADDLE      12'hF04
`define COLOR_BRICK0      12'hF00
`define COLOR_BRICK1      12'h0F0
`define COLOR_BRICK2      12'h00F
`define COLOR_BRICK3      12'hFF0
`define COLOR_BRICK4      12'h0FF
`define COLOR_BACKGROUND  12'h000

`endif
